//--- Bender.yml
package:
  name: wb_stage

sources:
  - files:
      - design/wb_pkg.sv
      - design/wb_entry_fifo.sv
      - design/wb_ctrl_decode.sv
      - design/wb_load_align.sv
      - design/wb_commit.sv
      - design/wb_regfile.sv
      - design/wb_top.sv
  - target: simulation
    files:
      - testbench/tb_clock_gen.sv
      - testbench/wb_tb.sv

//--- design/wb_commit.sv
module wb_commit (
    input  logic                          clk,
    input  logic                          rst_n_i,
    input  logic                          hold_i,
    input  logic                          pop_i,
    input  logic                          stage_valid_i,
    input  logic                          rf_we_i,
    input  wb_pkg::wb_sel_e               wb_sel_i,
    input  logic [wb_pkg::REG_ADDR_W-1:0] rd_i,
    input  logic [wb_pkg::XLEN-1:0]       pc_i,
    input  logic [wb_pkg::XLEN-1:0]       result_i,
    input  logic [wb_pkg::XLEN-1:0]       load_data_i,
    output logic                          wr_en_o,
    output logic [wb_pkg::REG_ADDR_W-1:0] wr_addr_o,
    output logic [wb_pkg::XLEN-1:0]       wr_data_o,
    output logic [wb_pkg::XLEN-1:0]       retired_count_o
);

    logic [wb_pkg::XLEN-1:0] result_q;
    logic                    commit;

    // ALU result of the instruction held in the stage
    always_ff @(posedge clk) begin
        if (pop_i) begin
            result_q <= result_i;
        end
    end

    // Stage leaves this cycle
    assign commit = stage_valid_i & ~hold_i;

    always_comb begin
        case (wb_sel_i)
            wb_pkg::WB_LINK: wr_data_o = pc_i + wb_pkg::PC_STEP;
            wb_pkg::WB_ALU:  wr_data_o = result_q;
            wb_pkg::WB_LOAD: wr_data_o = load_data_i;
            default:         wr_data_o = '0;
        endcase
    end

    // x0 is never written
    assign wr_en_o   = commit & rf_we_i & (rd_i != '0);
    assign wr_addr_o = rd_i;

    // Counts every retired instruction, writers or not
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            retired_count_o <= '0;
        end else if (commit) begin
            retired_count_o <= retired_count_o + 1'b1;
        end
    end

endmodule

//--- design/wb_ctrl_decode.sv
module wb_ctrl_decode (
    input  logic                          clk,
    input  logic                          rst_n_i,
    input  logic                          hold_i,
    input  logic                          head_valid_i,
    input  logic [wb_pkg::XLEN-1:0]       head_pc_i,
    input  logic [wb_pkg::XLEN-1:0]       head_inst_i,
    output logic                          pop_o,
    output logic                          stage_valid_o,
    output logic                          rf_we_o,
    output wb_pkg::wb_sel_e               wb_sel_o,
    output wb_pkg::load_kind_e            load_kind_o,
    output logic [wb_pkg::REG_ADDR_W-1:0] rd_o,
    output logic [wb_pkg::XLEN-1:0]       pc_o
);

    wb_pkg::opcode_e opcode;
    logic            we_d;
    wb_pkg::wb_sel_e sel_d;

    assign opcode = wb_pkg::opcode_e'(head_inst_i[6:0]);

    // Stage is free when empty or when its occupant commits this cycle
    assign pop_o = head_valid_i & (~stage_valid_o | ~hold_i);

    // Register writers
    always_comb begin
        case (opcode)
            wb_pkg::OP_LUI, wb_pkg::OP_AUIPC, wb_pkg::OP_JAL, wb_pkg::OP_JALR,
            wb_pkg::OP_LOAD, wb_pkg::OP_IMM, wb_pkg::OP_REG: we_d = 1'b1;
            default:                                          we_d = 1'b0;
        endcase
    end

    // Writeback source per opcode group
    always_comb begin
        case (opcode)
            wb_pkg::OP_JAL, wb_pkg::OP_JALR: sel_d = wb_pkg::WB_LINK;
            wb_pkg::OP_LOAD:                 sel_d = wb_pkg::WB_LOAD;
            wb_pkg::OP_LUI, wb_pkg::OP_AUIPC,
            wb_pkg::OP_IMM, wb_pkg::OP_REG:  sel_d = wb_pkg::WB_ALU;
            default:                         sel_d = wb_pkg::WB_NONE;
        endcase
    end

    // Stage register, captured on a pop and emptied when it commits
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            stage_valid_o <= 1'b0;
            rf_we_o       <= 1'b0;
            wb_sel_o      <= wb_pkg::WB_NONE;
            load_kind_o   <= wb_pkg::LD_W;
            rd_o          <= '0;
            pc_o          <= '0;
        end else if (pop_o) begin
            stage_valid_o <= 1'b1;
            rf_we_o       <= we_d;
            wb_sel_o      <= sel_d;
            load_kind_o   <= wb_pkg::load_kind_e'(head_inst_i[14:12]);
            rd_o          <= head_inst_i[11:7];
            pc_o          <= head_pc_i;
        end else if (!hold_i) begin
            stage_valid_o <= 1'b0;
        end
    end

    // Writer table and source table must agree
    assert property (@(posedge clk) disable iff (!rst_n_i)
        rf_we_o |-> (wb_sel_o != wb_pkg::WB_NONE))
        else $error("decode write enable without a writeback source");

endmodule

//--- design/wb_entry_fifo.sv
module wb_entry_fifo (
    input  logic                      clk,
    input  logic                      rst_n_i,
    input  logic                      push_i,
    input  logic [wb_pkg::XLEN-1:0]   push_pc_i,
    input  logic [wb_pkg::XLEN-1:0]   push_inst_i,
    input  logic [wb_pkg::XLEN-1:0]   push_result_i,
    input  logic [wb_pkg::XLEN-1:0]   push_ldata_i,
    input  logic                      pop_i,
    output logic                      head_valid_o,
    output logic [wb_pkg::XLEN-1:0]   head_pc_o,
    output logic [wb_pkg::XLEN-1:0]   head_inst_o,
    output logic [wb_pkg::XLEN-1:0]   head_result_o,
    output logic [wb_pkg::XLEN-1:0]   head_ldata_o,
    output logic                      credit_o
);

    logic [wb_pkg::XLEN-1:0] pc_mem     [wb_pkg::FIFO_DEPTH];
    logic [wb_pkg::XLEN-1:0] inst_mem   [wb_pkg::FIFO_DEPTH];
    logic [wb_pkg::XLEN-1:0] result_mem [wb_pkg::FIFO_DEPTH];
    logic [wb_pkg::XLEN-1:0] ldata_mem  [wb_pkg::FIFO_DEPTH];

    logic [$clog2(wb_pkg::FIFO_DEPTH)-1:0] wr_ptr;
    logic [$clog2(wb_pkg::FIFO_DEPTH)-1:0] rd_ptr;
    logic [wb_pkg::CREDIT_W-1:0]           count;

    // Storage, written at the tail
    always_ff @(posedge clk) begin
        if (push_i) begin
            pc_mem[wr_ptr]     <= push_pc_i;
            inst_mem[wr_ptr]   <= push_inst_i;
            result_mem[wr_ptr] <= push_result_i;
            ldata_mem[wr_ptr]  <= push_ldata_i;
        end
    end

    // Pointers, occupancy and the returned credit
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            credit_o <= 1'b0;
        end else begin
            if (push_i) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_i) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count    <= count + push_i - pop_i;
            // One slot freed per pop
            credit_o <= pop_i;
        end
    end

    assign head_valid_o  = (count != '0);
    assign head_pc_o     = pc_mem[rd_ptr];
    assign head_inst_o   = inst_mem[rd_ptr];
    assign head_result_o = result_mem[rd_ptr];
    assign head_ldata_o  = ldata_mem[rd_ptr];

    // Sender must never spend a credit it does not hold
    assert property (@(posedge clk) disable iff (!rst_n_i)
        push_i |-> (count != wb_pkg::CREDIT_W'(wb_pkg::FIFO_DEPTH)))
        else $error("entry buffer push while full");

    // Stage pair only pops a live head
    assert property (@(posedge clk) disable iff (!rst_n_i)
        pop_i |-> (count != '0))
        else $error("entry buffer pop while empty");

endmodule

//--- design/wb_load_align.sv
module wb_load_align (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  logic                    pop_i,
    input  logic [wb_pkg::XLEN-1:0] head_inst_i,
    input  logic [wb_pkg::XLEN-1:0] head_result_i,
    input  logic [wb_pkg::XLEN-1:0] head_ldata_i,
    output logic [wb_pkg::XLEN-1:0] load_data_o
);

    wb_pkg::load_kind_e      kind;
    logic [1:0]              offset;
    logic [7:0]              byte_lane;
    logic [15:0]             half_lane;
    logic [wb_pkg::XLEN-1:0] aligned;

    // Kind follows funct3, offset is the low address bits
    assign kind   = wb_pkg::load_kind_e'(head_inst_i[14:12]);
    assign offset = head_result_i[1:0];

    // Byte lane picked by the full offset
    always_comb begin
        case (offset)
            2'd0:    byte_lane = head_ldata_i[7:0];
            2'd1:    byte_lane = head_ldata_i[15:8];
            2'd2:    byte_lane = head_ldata_i[23:16];
            default: byte_lane = head_ldata_i[31:24];
        endcase
    end

    // Halfword uses the aligned lane, offset bit 0 is ignored
    assign half_lane = offset[1] ? head_ldata_i[31:16] : head_ldata_i[15:0];

    always_comb begin
        case (kind)
            wb_pkg::LD_B:  aligned = {{24{byte_lane[7]}}, byte_lane};
            wb_pkg::LD_BU: aligned = {24'd0, byte_lane};
            wb_pkg::LD_H:  aligned = {{16{half_lane[15]}}, half_lane};
            wb_pkg::LD_HU: aligned = {16'd0, half_lane};
            // Word, and any funct3 outside the load set
            default:       aligned = head_ldata_i;
        endcase
    end

    // Captured on the same pop as the decode half
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            load_data_o <= '0;
        end else if (pop_i) begin
            load_data_o <= aligned;
        end
    end

endmodule

//--- design/wb_pkg.sv
package wb_pkg;

    // Datapath and pc width
    localparam int XLEN = 32;

    // Integer register index
    localparam int REG_ADDR_W = 5;

    // Entry buffer slots, also the sender's starting credit count.
    // Kept a power of two so the pointers wrap on their own
    localparam int FIFO_DEPTH = 4;

    // Holds 0 to FIFO_DEPTH
    localparam int CREDIT_W = 3;

    // Link value offset for JAL and JALR
    localparam logic [XLEN-1:0] PC_STEP = 32'd4;

    // RV32I major opcodes, bits [6:0] of the instruction
    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011,
        OP_SYSTEM = 7'b1110011
    } opcode_e;

    // Writeback source select
    typedef enum logic [1:0] {
        WB_NONE = 2'b00,
        WB_LINK = 2'b01,
        WB_ALU  = 2'b10,
        WB_LOAD = 2'b11
    } wb_sel_e;

    // Load width and sign, encoded as funct3 of the load
    typedef enum logic [2:0] {
        LD_B  = 3'b000,
        LD_H  = 3'b001,
        LD_W  = 3'b010,
        LD_BU = 3'b100,
        LD_HU = 3'b101
    } load_kind_e;

endpackage

//--- design/wb_regfile.sv
module wb_regfile (
    input  logic                          clk,
    input  logic                          rst_n_i,
    input  logic                          wr_en_i,
    input  logic [wb_pkg::REG_ADDR_W-1:0] wr_addr_i,
    input  logic [wb_pkg::XLEN-1:0]       wr_data_i,
    input  logic [wb_pkg::REG_ADDR_W-1:0] rd_addr_i,
    output logic [wb_pkg::XLEN-1:0]       rd_data_o
);

    // x1 to x31 only, x0 has no storage
    logic [wb_pkg::XLEN-1:0] regs [1:31];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en_i && (wr_addr_i != '0)) begin
            regs[wr_addr_i] <= wr_data_i;
        end
    end

    // Operand read for the decode stage
    assign rd_data_o = (rd_addr_i == '0) ? '0 : regs[rd_addr_i];

    // Commit filters rd == 0 before it reaches here
    assert property (@(posedge clk) disable iff (!rst_n_i)
        wr_en_i |-> (wr_addr_i != '0))
        else $error("register file write to x0");

endmodule

//--- design/wb_top.sv
module wb_top (
    input  logic                          clk,
    input  logic                          rst_n_i,
    input  logic                          in_valid_i,
    input  logic [wb_pkg::XLEN-1:0]       in_pc_i,
    input  logic [wb_pkg::XLEN-1:0]       in_inst_i,
    input  logic [wb_pkg::XLEN-1:0]       in_result_i,
    input  logic [wb_pkg::XLEN-1:0]       in_ldata_i,
    input  logic                          hold_i,
    output logic                          credit_o,
    input  logic [wb_pkg::REG_ADDR_W-1:0] rf_raddr_i,
    output logic [wb_pkg::XLEN-1:0]       rf_rdata_o,
    output logic [wb_pkg::XLEN-1:0]       retired_count_o
);

    // Buffer head
    logic                          head_valid;
    logic [wb_pkg::XLEN-1:0]       head_pc;
    logic [wb_pkg::XLEN-1:0]       head_inst;
    logic [wb_pkg::XLEN-1:0]       head_result;
    logic [wb_pkg::XLEN-1:0]       head_ldata;
    logic                          pop;

    // Stage registers
    logic                          stage_valid;
    logic                          stage_we;
    wb_pkg::wb_sel_e               stage_sel;
    wb_pkg::load_kind_e            stage_kind;
    logic [wb_pkg::REG_ADDR_W-1:0] stage_rd;
    logic [wb_pkg::XLEN-1:0]       stage_pc;
    logic [wb_pkg::XLEN-1:0]       load_data;

    // Register write
    logic                          wr_en;
    logic [wb_pkg::REG_ADDR_W-1:0] wr_addr;
    logic [wb_pkg::XLEN-1:0]       wr_data;

    wb_entry_fifo u_fifo (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .push_i        (in_valid_i),
        .push_pc_i     (in_pc_i),
        .push_inst_i   (in_inst_i),
        .push_result_i (in_result_i),
        .push_ldata_i  (in_ldata_i),
        .pop_i         (pop),
        .head_valid_o  (head_valid),
        .head_pc_o     (head_pc),
        .head_inst_o   (head_inst),
        .head_result_o (head_result),
        .head_ldata_o  (head_ldata),
        .credit_o      (credit_o)
    );

    wb_ctrl_decode u_decode (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .hold_i        (hold_i),
        .head_valid_i  (head_valid),
        .head_pc_i     (head_pc),
        .head_inst_i   (head_inst),
        .pop_o         (pop),
        .stage_valid_o (stage_valid),
        .rf_we_o       (stage_we),
        .wb_sel_o      (stage_sel),
        .load_kind_o   (stage_kind),
        .rd_o          (stage_rd),
        .pc_o          (stage_pc)
    );

    // Second half of the stage, same pop as decode
    wb_load_align u_align (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .pop_i         (pop),
        .head_inst_i   (head_inst),
        .head_result_i (head_result),
        .head_ldata_i  (head_ldata),
        .load_data_o   (load_data)
    );

    wb_commit u_commit (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .hold_i          (hold_i),
        .pop_i           (pop),
        .stage_valid_i   (stage_valid),
        .rf_we_i         (stage_we),
        .wb_sel_i        (stage_sel),
        .rd_i            (stage_rd),
        .pc_i            (stage_pc),
        .result_i        (head_result),
        .load_data_i     (load_data),
        .wr_en_o         (wr_en),
        .wr_addr_o       (wr_addr),
        .wr_data_o       (wr_data),
        .retired_count_o (retired_count_o)
    );

    wb_regfile u_regfile (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .wr_en_i   (wr_en),
        .wr_addr_i (wr_addr),
        .wr_data_i (wr_data),
        .rd_addr_i (rf_raddr_i),
        .rd_data_o (rf_rdata_o)
    );

    // Both halves hold the same load, so an unsigned kind from decode
    // must meet zero upper bits from the aligner
    assert property (@(posedge clk) disable iff (!rst_n_i)
        (wr_en && stage_sel == wb_pkg::WB_LOAD && stage_kind == wb_pkg::LD_BU)
            |-> (wr_data[31:8] == '0))
        else $error("byte load kind and aligned data disagree");

    assert property (@(posedge clk) disable iff (!rst_n_i)
        (wr_en && stage_sel == wb_pkg::WB_LOAD && stage_kind == wb_pkg::LD_HU)
            |-> (wr_data[31:16] == '0))
        else $error("halfword load kind and aligned data disagree");

endmodule

//--- flist.f
design/wb_pkg.sv
design/wb_entry_fifo.sv
design/wb_ctrl_decode.sv
design/wb_load_align.sv
design/wb_commit.sv
design/wb_regfile.sv
design/wb_top.sv
testbench/tb_clock_gen.sv
testbench/wb_tb.sv

//--- testbench/tb_clock_gen.sv
module tb_clock_gen (
    output logic clk_o
);
    timeunit 1ns;
    timeprecision 100ps;

    // Half of the 4 ns period
    localparam int HALF_PERIOD = 2;

    initial begin
        clk_o = 1'b0;
        forever begin
            #HALF_PERIOD clk_o = ~clk_o;
        end
    end

endmodule

//--- testbench/wb_tb.sv
module wb_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 8;
    localparam int N_ARITH      = 24;
    localparam int N_JUMP       = 12;
    localparam int N_NOWR       = 16;
    localparam int N_HOLD       = 60;
    // Five load kinds at four offsets
    localparam int N_LOAD       = 20;
    localparam int TOTAL_INSTR  = N_ARITH + N_JUMP + N_LOAD + N_NOWR + N_HOLD;

    logic        clk;
    logic        rst_n_i;
    logic        in_valid_i;
    logic [31:0] in_pc_i;
    logic [31:0] in_inst_i;
    logic [31:0] in_result_i;
    logic [31:0] in_ldata_i;
    logic        hold_i;
    logic        credit_o;
    logic [4:0]  rf_raddr_i;
    logic [31:0] rf_rdata_o;
    logic [31:0] retired_count_o;

    logic [31:0]  lfsr_state;
    int           credits;
    int           sent_total;
    int           errors;
    int           checks;
    int           hold_left;
    bit           hold_random;
    logic [31:0]  model_regs [32];
    // Sent entries in order as {pc, inst, result, ldata}
    logic [127:0] sent_q [$];

    tb_clock_gen u_clk (.clk_o(clk));

    wb_top UUT (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .in_valid_i      (in_valid_i),
        .in_pc_i         (in_pc_i),
        .in_inst_i       (in_inst_i),
        .in_result_i     (in_result_i),
        .in_ldata_i      (in_ldata_i),
        .hold_i          (hold_i),
        .credit_o        (credit_o),
        .rf_raddr_i      (rf_raddr_i),
        .rf_rdata_o      (rf_rdata_o),
        .retired_count_o (retired_count_o)
    );

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            value = {value[30:0], lfsr_state[0]};
            if (lfsr_state[0]) begin
                lfsr_state = (lfsr_state >> 1) ^ 32'h80200003;
            end else begin
                lfsr_state = lfsr_state >> 1;
            end
        end
        return value;
    endfunction

    function automatic logic [6:0] opcode_at(input int idx);
        case (idx)
            0:       return wb_pkg::OP_LUI;
            1:       return wb_pkg::OP_AUIPC;
            2:       return wb_pkg::OP_JAL;
            3:       return wb_pkg::OP_JALR;
            4:       return wb_pkg::OP_BRANCH;
            5:       return wb_pkg::OP_LOAD;
            6:       return wb_pkg::OP_STORE;
            7:       return wb_pkg::OP_IMM;
            8:       return wb_pkg::OP_REG;
            default: return wb_pkg::OP_SYSTEM;
        endcase
    endfunction

    // Valid load funct3 values: lb, lh, lw, lbu, lhu
    function automatic logic [2:0] load_f3_at(input int idx);
        case (idx)
            0:       return 3'b000;
            1:       return 3'b001;
            2:       return 3'b010;
            3:       return 3'b100;
            default: return 3'b101;
        endcase
    endfunction

    // Expected load value from funct3, address offset and raw word
    function automatic logic [31:0] load_value(input logic [2:0] f3, input logic [1:0] off,
                                               input logic [31:0] word);
        logic [7:0]  b;
        logic [15:0] h;
        b = word[8*off +: 8];
        h = off[1] ? word[31:16] : word[15:0];
        case (f3)
            3'b000:  return {{24{b[7]}}, b};
            3'b100:  return {24'd0, b};
            3'b001:  return {{16{h[15]}}, h};
            3'b101:  return {16'd0, h};
            default: return word;
        endcase
    endfunction

    // Model update for one retired entry
    task automatic apply_entry(input logic [127:0] e);
        logic [31:0] pc;
        logic [31:0] inst;
        logic [31:0] result;
        logic [31:0] ldata;
        logic [31:0] value;
        logic        we;
        {pc, inst, result, ldata} = e;
        we = 1'b1;
        case (inst[6:0])
            wb_pkg::OP_LUI, wb_pkg::OP_AUIPC, wb_pkg::OP_IMM, wb_pkg::OP_REG: value = result;
            wb_pkg::OP_JAL, wb_pkg::OP_JALR: value = pc + 32'd4;
            wb_pkg::OP_LOAD: value = load_value(inst[14:12], result[1:0], ldata);
            default: begin
                value = '0;
                we    = 1'b0;
            end
        endcase
        if (we && inst[11:7] != 5'd0) begin
            model_regs[inst[11:7]] = value;
        end
    endtask

    // One falling edge: credit return, hold pattern, idle input
    task automatic tick();
        @(negedge clk);
        in_valid_i = 1'b0;
        if (credit_o) begin
            credits++;
        end
        if (credits > wb_pkg::FIFO_DEPTH) begin
            $display("Credit count %0d rose above the buffer depth at %0.1f ns",
                     credits, $realtime);
            errors++;
        end
        if (hold_random) begin
            if (hold_left > 0) begin
                hold_left--;
            end else if (rand_bits(2) == 0) begin
                hold_left = 1 + rand_bits(3);
            end
            hold_i = (hold_left > 0);
        end else begin
            hold_i = 1'b0;
        end
    endtask

    task automatic send(input logic [6:0] opcode, input logic [4:0] rd,
                        input logic [2:0] f3, input logic [31:0] result);
        logic [31:0] inst;
        logic [31:0] pc;
        logic [31:0] ldata;
        inst         = rand_bits(32);
        inst[6:0]    = opcode;
        inst[11:7]   = rd;
        inst[14:12]  = f3;
        pc           = {30'(rand_bits(30)), 2'b00};
        ldata        = rand_bits(32);
        tick();
        // Spend only credits we hold
        while (credits == 0) begin
            tick();
        end
        in_valid_i  = 1'b1;
        in_pc_i     = pc;
        in_inst_i   = inst;
        in_result_i = result;
        in_ldata_i  = ldata;
        credits--;
        sent_total++;
        sent_q.push_back({pc, inst, result, ldata});
    endtask

    task automatic drain_and_check(input int num, input string name, input int start_errors);
        hold_random = 1'b0;
        // All entries have left the buffer once every credit is home
        while (credits != wb_pkg::FIFO_DEPTH) begin
            tick();
        end
        // Last popped entry commits on the next edge
        repeat (2) tick();
        while (sent_q.size() > 0) begin
            apply_entry(sent_q.pop_front());
        end
        for (int i = 0; i < 32; i++) begin
            tick();
            rf_raddr_i = 5'(i);
            #1;
            checks++;
            if (rf_rdata_o !== model_regs[i]) begin
                $display("** Error at %0.1f ns: rf_rdata_o[x%0d] got %h expected %h",
                         $realtime, i, rf_rdata_o, model_regs[i]);
                errors++;
            end
        end
        $display("Test %0d %s finished with %0d errors", num, name, errors - start_errors);
    endtask

    initial begin
        #(CLK_PERIOD * (RESET_CYCLES + 20 * TOTAL_INSTR));
        $display("Watchdog expired at %0.1f ns with the tests unfinished", $realtime);
        $display("Verification failed");
        $finish;
    end

    initial begin
        int          start;
        logic [4:0]  rd;
        logic [2:0]  f3;
        logic [31:0] res;
        rst_n_i     = 1'b0;
        in_valid_i  = 1'b0;
        in_pc_i     = '0;
        in_inst_i   = '0;
        in_result_i = '0;
        in_ldata_i  = '0;
        hold_i      = 1'b0;
        rf_raddr_i  = '0;
        lfsr_state  = 32'hbb31;
        credits     = wb_pkg::FIFO_DEPTH;
        sent_total  = 0;
        errors      = 0;
        checks      = 0;
        hold_left   = 0;
        hold_random = 1'b0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n_i = 1'b1;

        // Distinct destinations so no result is overwritten before the check
        start = errors;
        for (int i = 0; i < N_ARITH; i++) begin
            rd  = 5'(i + 1);
            f3  = 3'(rand_bits(3));
            res = rand_bits(32);
            send(opcode_at((i % 2 == 0) ? (i % 4) / 2 : 7 + (i % 4) / 2), rd, f3, res);
        end
        drain_and_check(1, "arithmetic, lui and auipc", start);

        start = errors;
        for (int i = 0; i < N_JUMP; i++) begin
            rd  = 5'(i + 1);
            f3  = 3'(rand_bits(3));
            res = rand_bits(32);
            send(opcode_at(2 + i % 2), rd, f3, res);
        end
        drain_and_check(2, "jal and jalr link", start);

        start = errors;
        for (int i = 0; i < N_LOAD; i++) begin
            rd  = 5'(i + 1);
            res = {30'(rand_bits(30)), 2'(i % 4)};
            send(wb_pkg::OP_LOAD, rd, load_f3_at(i / 4), res);
        end
        drain_and_check(3, "load align and extend", start);

        start = errors;
        for (int i = 0; i < N_NOWR; i++) begin
            rd  = 5'(rand_bits(5));
            f3  = 3'(rand_bits(3));
            res = rand_bits(32);
            case (i % 4)
                0:       send(wb_pkg::OP_STORE, rd, f3, res);
                1:       send(wb_pkg::OP_BRANCH, rd, f3, res);
                2:       send(wb_pkg::OP_SYSTEM, rd, f3, res);
                // Writer aimed at x0
                default: send(opcode_at(rand_bits(4) % 10), 5'd0, 3'b010, res);
            endcase
        end
        drain_and_check(4, "no-write and x0", start);

        start       = errors;
        hold_random = 1'b1;
        for (int i = 0; i < N_HOLD; i++) begin
            int idx;
            idx = rand_bits(4) % 10;
            rd  = 5'(rand_bits(5));
            res = rand_bits(32);
            f3  = (idx == 5) ? load_f3_at(rand_bits(3) % 5) : 3'(rand_bits(3));
            send(opcode_at(idx), rd, f3, res);
        end
        drain_and_check(5, "random hold back-pressure", start);

        start = errors;
        checks++;
        if (retired_count_o !== sent_total) begin
            $display("** Error at %0.1f ns: retired_count_o got %0d expected %0d",
                     $realtime, retired_count_o, sent_total);
            errors++;
        end
        $display("Test 6 retired count finished with %0d errors", errors - start);

        $display("Summary: 6 tests, %0d instructions, %0d checks, %0d errors",
                 sent_total, checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule
